/* depar.f */
logic/depar_pkg.sv
logic/seg_fifo.sv
logic/depar_wait_segs.sv
logic/depar_seg_emit.sv
logic/depar_top.sv
verif/depar_properties.sv
verif/depar_tb.sv

/* Makefile */
TOP = depar_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it, log in sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f depar.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "^test passed$$" sim.log || (echo "simulation did not report a pass"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* verif/depar_tb.sv */
`timescale 1ns/1ps

module depar_tb import depar_pkg::*;;

	logic clk = 1'b0;
	logic aresetn;
	logic [seg_data_w-1:0] in_tdata;
	logic [seg_user_w-1:0] in_tuser;
	logic [seg_keep_w-1:0] in_tkeep;
	logic in_tlast;
	logic in_valid;
	logic in_ready;
	logic [vlan_w-1:0] vlan;
	logic vlan_valid;
	logic [seg_data_w-1:0] out_tdata;
	logic [seg_user_w-1:0] out_tuser;
	logic [seg_keep_w-1:0] out_tkeep;
	logic out_tlast;
	logic out_valid;
	logic out_ready;

	// 0 keeps out_ready high, 1 randomizes it, 2 holds it low
	int ready_mode = 0;
	int mismatches = 0;
	int other_errors = 0;
	string cur_test = "reset";

	logic [seg_data_w-1:0] exp_data[$];
	logic [seg_user_w-1:0] exp_user[$];
	logic [seg_keep_w-1:0] exp_keep[$];
	logic exp_last[$];
	logic exp_first[$];
	int exp_pkt[$];
	logic [vlan_w-1:0] vlan_hist[$];
	logic [vlan_w-1:0] last_vlan;
	logic vlan_seen = 1'b0;

	depar_top depar_top_inst (
		.clk(clk), .aresetn(aresetn),
		.in_tdata(in_tdata), .in_tuser(in_tuser), .in_tkeep(in_tkeep),
		.in_tlast(in_tlast), .in_valid(in_valid), .in_ready(in_ready),
		.vlan(vlan), .vlan_valid(vlan_valid),
		.out_tdata(out_tdata), .out_tuser(out_tuser), .out_tkeep(out_tkeep),
		.out_tlast(out_tlast), .out_valid(out_valid), .out_ready(out_ready)
	);

	always #10 clk = ~clk;

	always @(negedge clk) begin : drive_out_ready
		logic [31:0] rnd;
		rnd = $urandom();
		case (ready_mode)
			0: out_ready = 1'b1;
			1: out_ready = rnd[0];
			default: out_ready = 1'b0;
		endcase
	end

	always @(posedge clk) begin : check_output
		logic [seg_data_w-1:0] data;
		logic [seg_user_w-1:0] user;
		logic [seg_keep_w-1:0] keep;
		logic last;
		logic first;
		logic vlan_ok;
		int pkt;
		int j;
		if (aresetn && vlan_valid) begin
			last_vlan = vlan;
			vlan_seen = 1'b1;
		end
		if (aresetn && out_valid && out_ready) begin
			if (exp_data.size() == 0) begin
				other_errors++;
				$display("unexpected output segment in %s with nothing left to send", cur_test);
			end else begin
				data = exp_data.pop_front();
				user = exp_user.pop_front();
				keep = exp_keep.pop_front();
				last = exp_last.pop_front();
				first = exp_first.pop_front();
				pkt = exp_pkt.pop_front();
				if (out_tdata !== data) begin
					mismatches++;
					$display("Mismatch in %s tdata: expected %h, actual %h", cur_test, data, out_tdata);
				end
				if (out_tuser !== user) begin
					mismatches++;
					$display("Mismatch in %s tuser: expected %h, actual %h", cur_test, user, out_tuser);
				end
				if (out_tkeep !== keep) begin
					mismatches++;
					$display("Mismatch in %s tkeep: expected %h, actual %h", cur_test, keep, out_tkeep);
				end
				if (out_tlast !== last) begin
					mismatches++;
					$display("Mismatch in %s tlast: expected %b, actual %b", cur_test, last, out_tlast);
				end
				// the VLAN may already belong to a packet queued behind this one
				if (first) begin
					vlan_ok = 1'b0;
					for (j = pkt; j < vlan_hist.size(); j++) begin
						if (vlan_seen && vlan_hist[j] == last_vlan) begin
							vlan_ok = 1'b1;
						end
					end
					if (!vlan_ok) begin
						mismatches++;
						$display("Mismatch in %s vlan of packet %0d: expected %h, actual %h",
							cur_test, pkt, vlan_hist[pkt], last_vlan);
					end
				end
			end
		end
	end

	function automatic logic [vlan_w-1:0] random_vlan();
		logic [31:0] rnd;
		rnd = $urandom();
		return rnd[vlan_w-1:0];
	endfunction

	// called on a falling edge, returns on a falling edge
	task automatic send_packet(input int len, input logic [vlan_w-1:0] vlan_id);
		logic [seg_data_w-1:0] data;
		logic [31:0] rnd;
		int i;
		vlan_hist.push_back(vlan_id);
		for (i = 0; i < len; i++) begin
			data = {$urandom(), $urandom(), $urandom(), $urandom()};
			if (i == 0) begin
				data[vlan_lsb +: vlan_w] = vlan_id;
			end
			rnd = $urandom();
			in_tdata = data;
			in_tuser = $urandom();
			in_tkeep = rnd[seg_keep_w-1:0];
			in_tlast = (i == len - 1);
			in_valid = 1'b1;
			exp_data.push_back(data);
			exp_user.push_back(in_tuser);
			exp_keep.push_back(in_tkeep);
			exp_last.push_back(in_tlast);
			exp_first.push_back(i == 0);
			exp_pkt.push_back(vlan_hist.size() - 1);
			@(posedge clk);
			while (!in_ready) begin
				@(posedge clk);
			end
			@(negedge clk);
		end
		in_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_data.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic single_seg_packets();
		logic [vlan_w-1:0] vlan_id;
		int k;
		cur_test = "single_seg_packets";
		for (k = 0; k < 4; k++) begin
			vlan_id = random_vlan();
			send_packet(1, vlan_id);
			wait_drain();
			if (last_vlan !== vlan_id) begin
				mismatches++;
				$display("Mismatch in %s vlan: expected %h, actual %h", cur_test, vlan_id, last_vlan);
			end
		end
	endtask

	task automatic short_packets_back_to_back();
		cur_test = "short_packets_back_to_back";
		send_packet(2, random_vlan());
		send_packet(3, random_vlan());
		send_packet(4, random_vlan());
		wait_drain();
	endtask

	task automatic long_packets_flush();
		cur_test = "long_packets_flush";
		send_packet(7, random_vlan());
		send_packet(12, random_vlan());
		wait_drain();
	endtask

	task automatic stalled_output();
		int n;
		int k;
		cur_test = "stalled_output";
		ready_mode = 2;
		fork
			begin
				for (k = 0; k < 24; k++) begin
					send_packet(1, random_vlan());
				end
			end
			begin
				n = 0;
				while (in_ready && n < 200) begin
					@(posedge clk);
					n++;
				end
				if (in_ready) begin
					other_errors++;
					$display("in_ready stayed high in %s although the output was held", cur_test);
				end
				repeat (10) @(negedge clk);
				ready_mode = 1;
			end
		join
		for (k = 0; k < 20; k++) begin
			send_packet(1 + int'($urandom() % 6), random_vlan());
		end
		wait_drain();
		ready_mode = 0;
	endtask

	task automatic random_length_packets();
		int k;
		cur_test = "random_length_packets";
		for (k = 0; k < 60; k++) begin
			send_packet(1 + int'($urandom() % 10), random_vlan());
		end
		wait_drain();
	endtask

	initial begin : watchdog
		int limit;
		// segment count of all tests, worst case for the random lengths
		limit = (4 + 9 + 19 + 24 + 120 + 600) * 40 + 1000;
		repeat (limit) @(posedge clk);
		$display("timeout: the run did not finish within %0d clock cycles", limit);
		$display("test failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hdd57_76aa));
		aresetn = 1'b0;
		in_tdata = '0;
		in_tuser = '0;
		in_tkeep = '0;
		in_tlast = 1'b0;
		in_valid = 1'b0;
		out_ready = 1'b1;
		repeat (8) @(negedge clk);
		aresetn = 1'b1;
		repeat (2) @(negedge clk);
		single_seg_packets();
		short_packets_back_to_back();
		long_packets_flush();
		stalled_output();
		random_length_packets();
		$display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
		if (mismatches + other_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* verif/depar_properties.sv */
`timescale 1ns/1ps

module depar_properties import depar_pkg::*; (
	input logic        clk,
	input logic        aresetn,
	input logic        out_valid,
	input logic        out_tlast,
	input logic        fst_half_valid,
	input logic        fst_fifo_full,
	input logic        snd_half_valid,
	input logic        snd_fifo_full,
	input wait_state_t gather_state
);

	// the emitter leaves its first reset edge in idle, so only later reset cycles count
	no_out_valid_in_reset: assert property (@(posedge clk)
		(!aresetn && $past(!aresetn)) |-> !out_valid)
		else $error("out_valid is high while reset is held");

	no_fst_write_when_full: assert property (@(posedge clk) disable iff (!aresetn)
		fst_half_valid |-> !fst_fifo_full)
		else $error("first-half queue written while full");

	no_snd_write_when_full: assert property (@(posedge clk) disable iff (!aresetn)
		snd_half_valid |-> !snd_fifo_full)
		else $error("second-half queue written while full");

	tlast_needs_valid: assert property (@(posedge clk) disable iff (!aresetn)
		out_tlast |-> out_valid)
		else $error("out_tlast is high without out_valid");

	legal_gather_state: assert property (@(posedge clk) disable iff (!aresetn)
		gather_state inside {wait_first_seg, wait_second_seg, wait_third_seg,
			wait_fourth_seg, flush_seg})
		else $error("gatherer FSM is in an undefined state");

endmodule

bind depar_top depar_properties depar_properties_inst (
	.clk(clk),
	.aresetn(aresetn),
	.out_valid(out_valid),
	.out_tlast(out_tlast),
	.fst_half_valid(fst_half_valid),
	.fst_fifo_full(fst_fifo_full),
	.snd_half_valid(snd_half_valid),
	.snd_fifo_full(snd_fifo_full),
	.gather_state(wait_segs_inst.state)
);

/* logic/depar_top.sv */
`timescale 1ns/1ps

module depar_top import depar_pkg::*; (
	input  logic                  clk,
	input  logic                  aresetn,
	input  logic [seg_data_w-1:0] in_tdata,
	input  logic [seg_user_w-1:0] in_tuser,
	input  logic [seg_keep_w-1:0] in_tkeep,
	input  logic                  in_tlast,
	input  logic                  in_valid,
	output logic                  in_ready,
	output logic [vlan_w-1:0]     vlan,
	output logic                  vlan_valid,
	output logic [seg_data_w-1:0] out_tdata,
	output logic [seg_user_w-1:0] out_tuser,
	output logic [seg_keep_w-1:0] out_tkeep,
	output logic                  out_tlast,
	output logic                  out_valid,
	input  logic                  out_ready
);

	logic [seg_data_w-1:0] pkt_fifo_tdata, rem_fifo_tdata, output_fifo_tdata;
	logic [seg_user_w-1:0] pkt_fifo_tuser, rem_fifo_tuser, output_fifo_tuser;
	logic [seg_keep_w-1:0] pkt_fifo_tkeep, rem_fifo_tkeep, output_fifo_tkeep;
	logic pkt_fifo_tlast, rem_fifo_tlast, output_fifo_tlast;
	logic pkt_fifo_empty, pkt_fifo_full, pkt_fifo_rd_en;
	logic rem_fifo_empty, rem_fifo_full, rem_fifo_rd_en, output_fifo_valid;

	logic [half_data_w-1:0] fst_half_tdata, snd_half_tdata, fst_fifo_tdata, snd_fifo_tdata;
	logic [half_user_w-1:0] fst_half_tuser, snd_half_tuser, fst_fifo_tuser, snd_fifo_tuser;
	logic [half_keep_w-1:0] fst_half_tkeep, snd_half_tkeep, fst_fifo_tkeep, snd_fifo_tkeep;
	logic [half_segs-1:0] fst_half_tlast, snd_half_tlast, fst_fifo_tlast, snd_fifo_tlast;
	logic fst_half_valid, fst_fifo_empty, fst_fifo_full, fst_fifo_rd_en;
	logic snd_half_valid, snd_fifo_empty, snd_fifo_full, snd_fifo_rd_en;

	assign in_ready = !pkt_fifo_full;

	seg_fifo #(.depth(pkt_fifo_depth), .width(seg_bus_w)) pkt_fifo_inst (
		.clk(clk), .aresetn(aresetn),
		.wr_en(in_valid && in_ready), .din({in_tdata, in_tuser, in_tkeep, in_tlast}),
		.rd_en(pkt_fifo_rd_en),
		.dout({pkt_fifo_tdata, pkt_fifo_tuser, pkt_fifo_tkeep, pkt_fifo_tlast}),
		.empty(pkt_fifo_empty), .full(pkt_fifo_full)
	);

	depar_wait_segs wait_segs_inst (
		.clk(clk), .aresetn(aresetn),
		.pkt_fifo_tdata(pkt_fifo_tdata), .pkt_fifo_tuser(pkt_fifo_tuser),
		.pkt_fifo_tkeep(pkt_fifo_tkeep), .pkt_fifo_tlast(pkt_fifo_tlast),
		.pkt_fifo_empty(pkt_fifo_empty), .pkt_fifo_rd_en(pkt_fifo_rd_en),
		.vlan(vlan), .vlan_valid(vlan_valid),
		.fst_half_tdata(fst_half_tdata), .fst_half_tuser(fst_half_tuser),
		.fst_half_tkeep(fst_half_tkeep), .fst_half_tlast(fst_half_tlast),
		.fst_half_valid(fst_half_valid), .fst_half_fifo_ready(!fst_fifo_full),
		.snd_half_tdata(snd_half_tdata), .snd_half_tuser(snd_half_tuser),
		.snd_half_tkeep(snd_half_tkeep), .snd_half_tlast(snd_half_tlast),
		.snd_half_valid(snd_half_valid), .snd_half_fifo_ready(!snd_fifo_full),
		.output_fifo_tdata(output_fifo_tdata), .output_fifo_tuser(output_fifo_tuser),
		.output_fifo_tkeep(output_fifo_tkeep), .output_fifo_tlast(output_fifo_tlast),
		.output_fifo_valid(output_fifo_valid), .output_fifo_ready(!rem_fifo_full)
	);

	seg_fifo #(.depth(half_fifo_depth), .width(half_bus_w)) fst_fifo_inst (
		.clk(clk), .aresetn(aresetn), .wr_en(fst_half_valid),
		.din({fst_half_tdata, fst_half_tuser, fst_half_tkeep, fst_half_tlast}),
		.rd_en(fst_fifo_rd_en),
		.dout({fst_fifo_tdata, fst_fifo_tuser, fst_fifo_tkeep, fst_fifo_tlast}),
		.empty(fst_fifo_empty), .full(fst_fifo_full)
	);

	seg_fifo #(.depth(half_fifo_depth), .width(half_bus_w)) snd_fifo_inst (
		.clk(clk), .aresetn(aresetn), .wr_en(snd_half_valid),
		.din({snd_half_tdata, snd_half_tuser, snd_half_tkeep, snd_half_tlast}),
		.rd_en(snd_fifo_rd_en),
		.dout({snd_fifo_tdata, snd_fifo_tuser, snd_fifo_tkeep, snd_fifo_tlast}),
		.empty(snd_fifo_empty), .full(snd_fifo_full)
	);

	// segments past the fourth of a packet wait here
	seg_fifo #(.depth(rem_fifo_depth), .width(seg_bus_w)) rem_fifo_inst (
		.clk(clk), .aresetn(aresetn), .wr_en(output_fifo_valid),
		.din({output_fifo_tdata, output_fifo_tuser, output_fifo_tkeep, output_fifo_tlast}),
		.rd_en(rem_fifo_rd_en),
		.dout({rem_fifo_tdata, rem_fifo_tuser, rem_fifo_tkeep, rem_fifo_tlast}),
		.empty(rem_fifo_empty), .full(rem_fifo_full)
	);

	depar_seg_emit seg_emit_inst (
		.clk(clk), .aresetn(aresetn),
		.fst_tdata(fst_fifo_tdata), .fst_tuser(fst_fifo_tuser), .fst_tkeep(fst_fifo_tkeep),
		.fst_tlast(fst_fifo_tlast), .fst_empty(fst_fifo_empty),
		.snd_tdata(snd_fifo_tdata), .snd_tuser(snd_fifo_tuser), .snd_tkeep(snd_fifo_tkeep),
		.snd_tlast(snd_fifo_tlast), .snd_empty(snd_fifo_empty),
		.rem_tdata(rem_fifo_tdata), .rem_tuser(rem_fifo_tuser), .rem_tkeep(rem_fifo_tkeep),
		.rem_tlast(rem_fifo_tlast), .rem_empty(rem_fifo_empty),
		.out_ready(out_ready),
		.fst_rd_en(fst_fifo_rd_en), .snd_rd_en(snd_fifo_rd_en), .rem_rd_en(rem_fifo_rd_en),
		.out_tdata(out_tdata), .out_tuser(out_tuser), .out_tkeep(out_tkeep),
		.out_tlast(out_tlast), .out_valid(out_valid)
	);

endmodule

/* logic/depar_seg_emit.sv */
`timescale 1ns/1ps

module depar_seg_emit import depar_pkg::*; (
	input  logic                   clk,
	input  logic                   aresetn,

	input  logic [half_data_w-1:0] fst_tdata,
	input  logic [half_user_w-1:0] fst_tuser,
	input  logic [half_keep_w-1:0] fst_tkeep,
	input  logic [half_segs-1:0]   fst_tlast,
	input  logic                   fst_empty,

	input  logic [half_data_w-1:0] snd_tdata,
	input  logic [half_user_w-1:0] snd_tuser,
	input  logic [half_keep_w-1:0] snd_tkeep,
	input  logic [half_segs-1:0]   snd_tlast,
	input  logic                   snd_empty,

	input  logic [seg_data_w-1:0]  rem_tdata,
	input  logic [seg_user_w-1:0]  rem_tuser,
	input  logic [seg_keep_w-1:0]  rem_tkeep,
	input  logic                   rem_tlast,
	input  logic                   rem_empty,

	input  logic                   out_ready,
	output logic                   fst_rd_en,
	output logic                   snd_rd_en,
	output logic                   rem_rd_en,
	output logic [seg_data_w-1:0]  out_tdata,
	output logic [seg_user_w-1:0]  out_tuser,
	output logic [seg_keep_w-1:0]  out_tkeep,
	output logic                   out_tlast,
	output logic                   out_valid
);

	emit_state_t state;
	emit_state_t state_next;
	logic [seg_idx_w-1:0] seg_idx;
	logic [seg_idx_w-1:0] seg_idx_next;
	logic in_fst;
	logic seg_last;
	logic [half_data_w-1:0] cur_tdata;
	logic [half_user_w-1:0] cur_tuser;
	logic [half_keep_w-1:0] cur_tkeep;
	logic [half_segs-1:0] cur_tlast;
	logic cur_empty;

	assign in_fst = (state == emit_fst);
	assign cur_tdata = in_fst ? fst_tdata : snd_tdata;
	assign cur_tuser = in_fst ? fst_tuser : snd_tuser;
	assign cur_tkeep = in_fst ? fst_tkeep : snd_tkeep;
	assign cur_tlast = in_fst ? fst_tlast : snd_tlast;
	assign cur_empty = in_fst ? fst_empty : snd_empty;

	assign out_tlast = out_valid && seg_last;

	always_comb begin
		state_next = state;
		seg_idx_next = seg_idx;
		fst_rd_en = 1'b0;
		snd_rd_en = 1'b0;
		rem_rd_en = 1'b0;
		out_valid = 1'b0;
		out_tdata = '0;
		out_tuser = '0;
		out_tkeep = '0;
		seg_last = 1'b0;
		case (state)
			emit_idle: begin
				if (!fst_empty) begin
					state_next = emit_fst;
				end
			end
			emit_fst, emit_snd: begin
				out_tdata = cur_tdata[seg_idx*seg_data_w +: seg_data_w];
				out_tuser = cur_tuser[seg_idx*seg_user_w +: seg_user_w];
				out_tkeep = cur_tkeep[seg_idx*seg_keep_w +: seg_keep_w];
				seg_last = cur_tlast[seg_idx];
				// a packet ending in the first half also owns the stale second half
				out_valid = !cur_empty && !(in_fst && seg_last && snd_empty);
				if (out_valid && out_ready) begin
					if (seg_last) begin
						fst_rd_en = in_fst;
						snd_rd_en = 1'b1;
						seg_idx_next = '0;
						state_next = emit_idle;
					end else if (seg_idx == seg_idx_w'(half_segs - 1)) begin
						fst_rd_en = in_fst;
						snd_rd_en = !in_fst;
						seg_idx_next = '0;
						state_next = in_fst ? emit_snd : emit_rem;
					end else begin
						seg_idx_next = seg_idx + 1'b1;
					end
				end
			end
			emit_rem: begin
				out_tdata = rem_tdata;
				out_tuser = rem_tuser;
				out_tkeep = rem_tkeep;
				seg_last = rem_tlast;
				out_valid = !rem_empty;
				if (out_valid && out_ready) begin
					rem_rd_en = 1'b1;
					if (rem_tlast) begin
						state_next = emit_idle;
					end
				end
			end
			default: state_next = emit_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= emit_idle;
			seg_idx <= '0;
		end else begin
			state <= state_next;
			seg_idx <= seg_idx_next;
		end
	end

endmodule

/* logic/depar_wait_segs.sv */
`timescale 1ns/1ps

module depar_wait_segs import depar_pkg::*; (
	input  logic                   clk,
	input  logic                   aresetn,

	input  logic [seg_data_w-1:0]  pkt_fifo_tdata,
	input  logic [seg_user_w-1:0]  pkt_fifo_tuser,
	input  logic [seg_keep_w-1:0]  pkt_fifo_tkeep,
	input  logic                   pkt_fifo_tlast,
	input  logic                   pkt_fifo_empty,
	output logic                   pkt_fifo_rd_en,

	output logic [vlan_w-1:0]      vlan,
	output logic                   vlan_valid,

	output logic [half_data_w-1:0] fst_half_tdata,
	output logic [half_user_w-1:0] fst_half_tuser,
	output logic [half_keep_w-1:0] fst_half_tkeep,
	output logic [half_segs-1:0]   fst_half_tlast,
	output logic                   fst_half_valid,
	input  logic                   fst_half_fifo_ready,

	output logic [half_data_w-1:0] snd_half_tdata,
	output logic [half_user_w-1:0] snd_half_tuser,
	output logic [half_keep_w-1:0] snd_half_tkeep,
	output logic [half_segs-1:0]   snd_half_tlast,
	output logic                   snd_half_valid,
	input  logic                   snd_half_fifo_ready,

	output logic [seg_data_w-1:0]  output_fifo_tdata,
	output logic [seg_user_w-1:0]  output_fifo_tuser,
	output logic [seg_keep_w-1:0]  output_fifo_tkeep,
	output logic                   output_fifo_tlast,
	output logic                   output_fifo_valid,
	input  logic                   output_fifo_ready
);

	wait_state_t state;
	wait_state_t state_next;
	logic fst_push;
	logic snd_push;
	logic fst_ok;
	logic snd_ok;
	logic store_fst;
	logic store_snd;
	logic [seg_idx_w-1:0] store_idx;

	// the half write lands one cycle late, so a push still in flight
	// counts as one more entry in that queue
	assign fst_ok = fst_half_fifo_ready && !fst_half_valid;
	assign snd_ok = snd_half_fifo_ready && !snd_half_valid;

	assign store_fst = (state == wait_first_seg) || (state == wait_second_seg);
	assign store_snd = (state == wait_third_seg) || (state == wait_fourth_seg);
	assign store_idx = ((state == wait_second_seg) || (state == wait_fourth_seg)) ? 1'b1 : 1'b0;

	// remainder segments go through untouched
	assign output_fifo_tdata = pkt_fifo_tdata;
	assign output_fifo_tuser = pkt_fifo_tuser;
	assign output_fifo_tkeep = pkt_fifo_tkeep;
	assign output_fifo_tlast = pkt_fifo_tlast;

	always_comb begin
		state_next = state;
		pkt_fifo_rd_en = 1'b0;
		fst_push = 1'b0;
		snd_push = 1'b0;
		output_fifo_valid = 1'b0;
		case (state)
			wait_first_seg, wait_second_seg: begin
				if (!pkt_fifo_empty) begin
					if (pkt_fifo_tlast) begin
						// short packet, both halves go out so the emitter stays aligned
						if (fst_ok && snd_ok) begin
							pkt_fifo_rd_en = 1'b1;
							fst_push = 1'b1;
							snd_push = 1'b1;
							state_next = wait_first_seg;
						end
					end else if (state == wait_first_seg) begin
						pkt_fifo_rd_en = 1'b1;
						state_next = wait_second_seg;
					end else if (fst_ok) begin
						pkt_fifo_rd_en = 1'b1;
						fst_push = 1'b1;
						state_next = wait_third_seg;
					end
				end
			end
			wait_third_seg: begin
				if (!pkt_fifo_empty) begin
					if (!pkt_fifo_tlast) begin
						pkt_fifo_rd_en = 1'b1;
						state_next = wait_fourth_seg;
					end else if (snd_ok) begin
						pkt_fifo_rd_en = 1'b1;
						snd_push = 1'b1;
						state_next = wait_first_seg;
					end
				end
			end
			wait_fourth_seg: begin
				if (!pkt_fifo_empty && snd_ok) begin
					pkt_fifo_rd_en = 1'b1;
					snd_push = 1'b1;
					state_next = pkt_fifo_tlast ? wait_first_seg : flush_seg;
				end
			end
			flush_seg: begin
				if (!pkt_fifo_empty && output_fifo_ready) begin
					pkt_fifo_rd_en = 1'b1;
					output_fifo_valid = 1'b1;
					if (pkt_fifo_tlast) begin
						state_next = wait_first_seg;
					end
				end
			end
			default: state_next = wait_first_seg;
		endcase
	end

	always_ff @(posedge clk) begin
		if (pkt_fifo_rd_en && store_fst) begin
			fst_half_tdata[store_idx*seg_data_w +: seg_data_w] <= pkt_fifo_tdata;
			fst_half_tuser[store_idx*seg_user_w +: seg_user_w] <= pkt_fifo_tuser;
			fst_half_tkeep[store_idx*seg_keep_w +: seg_keep_w] <= pkt_fifo_tkeep;
			fst_half_tlast[store_idx] <= pkt_fifo_tlast;
		end
		if (pkt_fifo_rd_en && store_snd) begin
			snd_half_tdata[store_idx*seg_data_w +: seg_data_w] <= pkt_fifo_tdata;
			snd_half_tuser[store_idx*seg_user_w +: seg_user_w] <= pkt_fifo_tuser;
			snd_half_tkeep[store_idx*seg_keep_w +: seg_keep_w] <= pkt_fifo_tkeep;
			snd_half_tlast[store_idx] <= pkt_fifo_tlast;
		end
		if (state == wait_first_seg && !pkt_fifo_empty) begin
			vlan <= pkt_fifo_tdata[vlan_lsb +: vlan_w];
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= wait_first_seg;
			fst_half_valid <= 1'b0;
			snd_half_valid <= 1'b0;
			vlan_valid <= 1'b0;
		end else begin
			state <= state_next;
			fst_half_valid <= fst_push;
			snd_half_valid <= snd_push;
			vlan_valid <= (state == wait_first_seg) && !pkt_fifo_empty;
		end
	end

endmodule

/* logic/seg_fifo.sv */
`timescale 1ns/1ps

module seg_fifo #(
	parameter int depth = 16,
	parameter int width = 8
) (
	input  logic             clk,
	input  logic             aresetn,
	input  logic             wr_en,
	input  logic [width-1:0] din,
	input  logic             rd_en,
	output logic [width-1:0] dout,
	output logic             empty,
	output logic             full
);

	logic [width-1:0] mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic [$clog2(depth+1)-1:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// head is shown straight from the array, so no read latency
	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == ($clog2(depth+1))'(depth));

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == ($clog2(depth))'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == ($clog2(depth))'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

/* logic/depar_pkg.sv */
package depar_pkg;

	localparam int seg_data_w = 128;
	localparam int seg_user_w = 32;
	localparam int seg_keep_w = seg_data_w / 8;

	localparam int num_segs = 4;
	localparam int half_segs = num_segs / 2;
	localparam int seg_idx_w = $clog2(half_segs);

	localparam int half_data_w = half_segs * seg_data_w;
	localparam int half_user_w = half_segs * seg_user_w;
	localparam int half_keep_w = half_segs * seg_keep_w;

	// one queue entry is data, user, keep and tlast packed together
	localparam int seg_bus_w = seg_data_w + seg_user_w + seg_keep_w + 1;
	localparam int half_bus_w = half_data_w + half_user_w + half_keep_w + half_segs;

	localparam int vlan_lsb = 116;
	localparam int vlan_w = 12;

	localparam int pkt_fifo_depth = 16;
	localparam int half_fifo_depth = 4;
	localparam int rem_fifo_depth = 16;

	typedef enum logic [2:0] {
		wait_first_seg,
		wait_second_seg,
		wait_third_seg,
		wait_fourth_seg,
		flush_seg
	} wait_state_t;

	typedef enum logic [1:0] {
		emit_idle,
		emit_fst,
		emit_snd,
		emit_rem
	} emit_state_t;

endpackage
